/* Bender.yml */
package:
  name: uart_word_tx

sources:
  # Shared package first
  - common/uart_word_pkg.sv
  # RTL
  - hdl/word_fifo.sv
  - hdl/uart_buffer.sv
  - uart/uart_tx.sv
  - hdl/wb_tx_regs.sv
  - hdl/uart_word_tx_top.sv
  # Testbench
  - target: test
    files:
      - tests/tb_uart_word_tx.sv

/* common/uart_word_pkg.sv */
package uart_word_pkg;

    // Host word, also the width of one FIFO entry
    localparam int WORD_BITS = 32;

    // One UART character
    localparam int BYTE_BITS = 8;

    // Bytes sent per host word, LSB first
    localparam int BYTES_PER_WORD = WORD_BITS / BYTE_BITS;

    // Wishbone byte address width
    localparam int ADR_BITS = 4;

    // Register map, byte offsets
    localparam int REG_TXDATA = 0;
    localparam int REG_STATUS = 4;

    // Status word bit positions
    localparam int STAT_EMPTY = 0;
    localparam int STAT_FULL  = 1;
    localparam int STAT_DONE  = 2;

endpackage

/* hdl/uart_buffer.sv */
`timescale 1ns/1ps

module uart_buffer (
    input  logic                                i_clk,
    input  logic                                i_reset,

    // FIFO side
    input  logic                                i_fifo_empty,
    output logic                                o_fifo_rd,
    input  logic [uart_word_pkg::WORD_BITS-1:0] i_fifo_data,

    // Transmitter side
    input  logic                                i_uart_done,
    output logic                                o_uart_start,
    output logic [uart_word_pkg::BYTE_BITS-1:0] o_uart_data,

    output logic                                o_all_done
);

    localparam int IDX_BITS = $clog2(uart_word_pkg::BYTES_PER_WORD);
    localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(uart_word_pkg::BYTES_PER_WORD - 1);

    localparam logic [1:0] S_IDLE      = 2'd0;
    localparam logic [1:0] S_LOAD      = 2'd1;
    localparam logic [1:0] S_SEND      = 2'd2;
    localparam logic [1:0] S_WAIT_DONE = 2'd3;

    logic [1:0] state;
    logic [1:0] next_state;

    logic [uart_word_pkg::WORD_BITS-1:0] buffer_reg;
    logic [IDX_BITS-1:0]                 byte_index;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state      <= S_IDLE;
            byte_index <= '0;
        end else begin
            state <= next_state;
            if (state == S_LOAD) begin
                byte_index <= '0;
            end else if (state == S_WAIT_DONE && i_uart_done && byte_index != LAST_IDX) begin
                byte_index <= byte_index + 1'b1;
            end
        end
    end

    // Word arrives one cycle after the pop
    always_ff @(posedge i_clk) begin
        if (state == S_LOAD) begin
            buffer_reg <= i_fifo_data;
        end
    end

    // Current byte, stable from LOAD through the whole frame
    assign o_uart_data = buffer_reg[byte_index * uart_word_pkg::BYTE_BITS +:
                                    uart_word_pkg::BYTE_BITS];

    always_comb begin
        next_state   = state;
        o_fifo_rd    = 1'b0;
        o_uart_start = 1'b0;
        o_all_done   = 1'b0;

        case (state)
            S_IDLE: begin
                if (!i_fifo_empty) begin
                    o_fifo_rd  = 1'b1;
                    next_state = S_LOAD;
                end else begin
                    o_all_done = 1'b1;
                end
            end

            S_LOAD: begin
                next_state = S_SEND;
            end

            S_SEND: begin
                o_uart_start = 1'b1;
                next_state   = S_WAIT_DONE;
            end

            S_WAIT_DONE: begin
                if (i_uart_done) begin
                    // After the top byte go back for the next word
                    if (byte_index == LAST_IDX) begin
                        next_state = S_IDLE;
                    end else begin
                        next_state = S_SEND;
                    end
                end
            end

            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

endmodule

/* hdl/uart_word_tx_top.sv */
`timescale 1ns/1ps

module uart_word_tx_top #(
    parameter int CLKS_PER_BIT   = 868,
    parameter int FIFO_ADDR_BITS = 4
) (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_wb_cyc,
    input  logic                                i_wb_stb,
    input  logic                                i_wb_we,
    input  logic [uart_word_pkg::ADR_BITS-1:0]  i_wb_adr,
    input  logic [uart_word_pkg::WORD_BITS-1:0] i_wb_dat,
    output logic [uart_word_pkg::WORD_BITS-1:0] o_wb_dat,
    output logic                                o_wb_ack,
    output logic                                o_tx,
    output logic                                o_all_done
);

    logic                                fifo_wr;
    logic [uart_word_pkg::WORD_BITS-1:0] fifo_wdata;
    logic                                fifo_rd;
    logic [uart_word_pkg::WORD_BITS-1:0] fifo_rdata;
    logic                                fifo_empty;
    logic                                fifo_full;
    logic                                uart_start;
    logic                                uart_done;
    logic [uart_word_pkg::BYTE_BITS-1:0] uart_data;

    wb_tx_regs u_regs (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_adr     (i_wb_adr),
        .i_wb_dat     (i_wb_dat),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .i_fifo_full  (fifo_full),
        .i_fifo_empty (fifo_empty),
        .i_all_done   (o_all_done),
        .o_fifo_wr    (fifo_wr),
        .o_fifo_wdata (fifo_wdata)
    );

    word_fifo #(
        .FIFO_ADDR_BITS (FIFO_ADDR_BITS)
    ) u_fifo (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_wr    (fifo_wr),
        .i_wdata (fifo_wdata),
        .i_rd    (fifo_rd),
        .o_rdata (fifo_rdata),
        .o_empty (fifo_empty),
        .o_full  (fifo_full)
    );

    uart_buffer u_buffer (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_fifo_empty (fifo_empty),
        .o_fifo_rd    (fifo_rd),
        .i_fifo_data  (fifo_rdata),
        .i_uart_done  (uart_done),
        .o_uart_start (uart_start),
        .o_uart_data  (uart_data),
        .o_all_done   (o_all_done)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_start (uart_start),
        .i_data  (uart_data),
        .o_tx    (o_tx),
        .o_done  (uart_done)
    );

endmodule

/* hdl/wb_tx_regs.sv */
`timescale 1ns/1ps

module wb_tx_regs (
    input  logic                                i_clk,
    input  logic                                i_reset,

    // Wishbone classic slave
    input  logic                                i_wb_cyc,
    input  logic                                i_wb_stb,
    input  logic                                i_wb_we,
    input  logic [uart_word_pkg::ADR_BITS-1:0]  i_wb_adr,
    input  logic [uart_word_pkg::WORD_BITS-1:0] i_wb_dat,
    output logic [uart_word_pkg::WORD_BITS-1:0] o_wb_dat,
    output logic                                o_wb_ack,

    input  logic                                i_fifo_full,
    input  logic                                i_fifo_empty,
    input  logic                                i_all_done,
    output logic                                o_fifo_wr,
    output logic [uart_word_pkg::WORD_BITS-1:0] o_fifo_wdata
);

    logic                                valid;
    logic                                sel_data;
    logic                                sel_status;
    logic                                stall;
    logic                                ack_next;
    logic [uart_word_pkg::WORD_BITS-1:0] status_word;
    logic [uart_word_pkg::WORD_BITS-1:0] rd_word;

    // Ack cycle itself is not a new request
    assign valid      = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign sel_data   = (i_wb_adr == uart_word_pkg::ADR_BITS'(uart_word_pkg::REG_TXDATA));
    assign sel_status = (i_wb_adr == uart_word_pkg::ADR_BITS'(uart_word_pkg::REG_STATUS));

    // Hold off data writes while the FIFO has no room
    assign stall    = i_wb_we && sel_data && i_fifo_full;
    assign ack_next = valid && !stall;

    assign o_fifo_wr    = ack_next && i_wb_we && sel_data;
    assign o_fifo_wdata = i_wb_dat;

    always_comb begin
        status_word                           = '0;
        status_word[uart_word_pkg::STAT_EMPTY] = i_fifo_empty;
        status_word[uart_word_pkg::STAT_FULL]  = i_fifo_full;
        status_word[uart_word_pkg::STAT_DONE]  = i_all_done;
    end

    assign rd_word = sel_status ? status_word : '0;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= ack_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (ack_next) begin
            o_wb_dat <= rd_word;
        end
    end

endmodule

/* hdl/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo #(
    parameter int FIFO_ADDR_BITS = 4
) (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_wr,
    input  logic [uart_word_pkg::WORD_BITS-1:0] i_wdata,
    input  logic                                i_rd,
    output logic [uart_word_pkg::WORD_BITS-1:0] o_rdata,
    output logic                                o_empty,
    output logic                                o_full
);

    localparam int DEPTH = 1 << FIFO_ADDR_BITS;

    logic [uart_word_pkg::WORD_BITS-1:0] mem [DEPTH];

    // Extra MSB tells a wrapped write pointer from an equal one
    logic [FIFO_ADDR_BITS:0] wr_ptr;
    logic [FIFO_ADDR_BITS:0] rd_ptr;

    logic wr_en;
    logic rd_en;

    assign wr_en = i_wr && !o_full;
    assign rd_en = i_rd && !o_empty;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS]) &&
                     (wr_ptr[FIFO_ADDR_BITS-1:0] == rd_ptr[FIFO_ADDR_BITS-1:0]);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage and read port
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_ADDR_BITS-1:0]] <= i_wdata;
        end
        if (rd_en) begin
            o_rdata <= mem[rd_ptr[FIFO_ADDR_BITS-1:0]];
        end
    end

endmodule

/* tests/tb_uart_word_tx.sv */
`timescale 1ns/1ps

module tb_uart_word_tx;

    localparam int BIT_CLKS   = 8;
    localparam int WB_TIMEOUT = 2000;
    localparam int RX_TIMEOUT = 2000;
    localparam int QUIET_CLKS = 40 * BIT_CLKS;
    localparam int UNMAPPED   = 8;
    localparam logic [31:0] IDLE_STATUS = (32'd1 << uart_word_pkg::STAT_EMPTY) |
                                          (32'd1 << uart_word_pkg::STAT_DONE);
    localparam logic [31:0] FULL_STATUS = 32'd1 << uart_word_pkg::STAT_FULL;

    logic                                i_clk;
    logic                                i_reset;
    logic                                i_wb_cyc;
    logic                                i_wb_stb;
    logic                                i_wb_we;
    logic [uart_word_pkg::ADR_BITS-1:0]  i_wb_adr;
    logic [uart_word_pkg::WORD_BITS-1:0] i_wb_dat;
    logic [uart_word_pkg::WORD_BITS-1:0] o_wb_dat;
    logic                                o_wb_ack;
    logic                                o_tx;
    logic                                o_all_done;

    integer seed;
    int     ack_wait;

    uart_word_tx_top #(
        .CLKS_PER_BIT   (BIT_CLKS),
        .FIFO_ADDR_BITS (2)
    ) UUT (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .o_tx       (o_tx),
        .o_all_done (o_all_done)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #20 i_clk = ~i_clk;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout");
    endtask

    // Holds one classic cycle until ack and counts the stalled cycles in ack_wait
    task automatic wb_access(input logic we, input int adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int cnt;
        cnt = 0;
        @(negedge i_clk);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = uart_word_pkg::ADR_BITS'(adr);
        i_wb_dat = wdata;
        @(negedge i_clk);
        while (!o_wb_ack && cnt < WB_TIMEOUT) begin
            cnt++;
            @(negedge i_clk);
        end
        if (!o_wb_ack) begin
            report_timeout("Wishbone ack");
        end else begin
            rdata    = o_wb_dat;
            ack_wait = cnt;
            i_wb_cyc = 1'b0;
            i_wb_stb = 1'b0;
            i_wb_we  = 1'b0;
        end
    endtask

    task automatic wb_write(input int adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input int adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'h0, data);
    endtask

    // Samples mid-bit from half a bit after the falling start edge
    task automatic recv_byte(output logic [7:0] b);
        int cnt;
        int i;
        cnt = 0;
        @(negedge i_clk);
        while (o_tx && cnt < RX_TIMEOUT) begin
            cnt++;
            @(negedge i_clk);
        end
        if (o_tx) begin
            report_timeout("a start bit on o_tx");
        end else begin
            repeat (BIT_CLKS / 2) @(negedge i_clk);
            check("o_tx start bit", o_tx, 0);
            for (i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge i_clk);
                b[i] = o_tx;
            end
            repeat (BIT_CLKS) @(negedge i_clk);
            check("o_tx stop bit", o_tx, 1);
        end
    endtask

    task automatic recv_word(output logic [31:0] w);
        logic [7:0] b;
        int k;
        for (k = 0; k < 4; k++) begin
            recv_byte(b);
            w[k*8 +: 8] = b;
        end
    endtask

    task automatic wait_all_done();
        int cnt;
        cnt = 0;
        while (!o_all_done && cnt < RX_TIMEOUT) begin
            cnt++;
            @(negedge i_clk);
        end
        if (!o_all_done) begin
            report_timeout("o_all_done");
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge i_clk);
            check("o_tx idle", o_tx, 1);
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] rd;
        check("o_tx", o_tx, 1);
        check("o_all_done", o_all_done, 1);
        wb_read(uart_word_pkg::REG_STATUS, rd);
        check("status", rd, IDLE_STATUS);
    endtask

    task automatic test_single_word();
        logic [7:0] b;
        wb_write(uart_word_pkg::REG_TXDATA, 32'h4433_2211);
        recv_byte(b);
        check("byte 0", b, 8'h11);
        // Still three bytes to go
        check("o_all_done busy", o_all_done, 0);
        recv_byte(b);
        check("byte 1", b, 8'h22);
        recv_byte(b);
        check("byte 2", b, 8'h33);
        recv_byte(b);
        check("byte 3", b, 8'h44);
        wait_all_done();
    endtask

    task automatic test_fifo_full();
        logic [31:0] words [6];
        logic [31:0] rd;
        logic [31:0] w;
        words = '{32'hdead_beef, 32'h0123_4567, 32'h89ab_cdef,
                  32'ha5a5_5a5a, 32'h0f1e_2d3c, 32'hfeed_c0de};
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    wb_write(uart_word_pkg::REG_TXDATA, words[i]);
                    // Sixth write must stall until the first word leaves
                    if (i == 5) begin
                        check("write 6 stalled", ack_wait > 10 * BIT_CLKS, 1);
                    end
                    if (i == 4) begin
                        wb_read(uart_word_pkg::REG_STATUS, rd);
                        check("status while full", rd, FULL_STATUS);
                    end
                end
            end
            begin
                for (int j = 0; j < 6; j++) begin
                    recv_word(w);
                    check("received word", w, words[j]);
                end
            end
        join
        wait_all_done();
    endtask

    task automatic test_random_gaps();
        logic [31:0] words [8];
        logic [31:0] w;
        for (int i = 0; i < 8; i++) begin
            words[i] = $random(seed);
        end
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    repeat ($unsigned($random(seed)) % 300) @(negedge i_clk);
                    wb_write(uart_word_pkg::REG_TXDATA, words[i]);
                end
            end
            begin
                for (int j = 0; j < 8; j++) begin
                    recv_word(w);
                    check("random word", w, words[j]);
                end
            end
        join
        wait_all_done();
    endtask

    task automatic test_ignored_writes();
        logic [31:0] rd;
        wb_write(uart_word_pkg::REG_STATUS, 32'hffff_ffff);
        wb_write(UNMAPPED, 32'h1234_5678);
        expect_quiet(QUIET_CLKS);
        wb_read(UNMAPPED, rd);
        check("unmapped read", rd, 32'h0);
        wb_read(uart_word_pkg::REG_STATUS, rd);
        check("status after drain", rd, IDLE_STATUS);
    endtask

    initial begin
        i_reset  = 1'b1;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        ack_wait = 0;
        seed     = 32'hfe31_5daf;
        repeat (16) @(negedge i_clk);
        i_reset = 1'b0;

        test_reset_state();
        test_single_word();
        test_fifo_full();
        test_random_gaps();
        test_ignored_writes();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* uart/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_start,
    input  logic [uart_word_pkg::BYTE_BITS-1:0] i_data,
    output logic                                o_tx,
    output logic                                o_done
);

    localparam int CNT_BITS = $clog2(CLKS_PER_BIT);
    localparam int BIT_IDX_BITS = $clog2(uart_word_pkg::BYTE_BITS);
    localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(CLKS_PER_BIT - 1);
    localparam logic [BIT_IDX_BITS-1:0] BIT_LAST = BIT_IDX_BITS'(uart_word_pkg::BYTE_BITS - 1);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic [1:0]                          state;
    logic [CNT_BITS-1:0]                 clk_cnt;
    logic [BIT_IDX_BITS-1:0]             bit_cnt;
    logic [uart_word_pkg::BYTE_BITS-1:0] shift_reg;
    logic                                bit_end;

    assign bit_end = (clk_cnt == CNT_LAST);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state   <= S_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            o_tx    <= 1'b1;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;

            if (state == S_IDLE || bit_end) begin
                clk_cnt <= '0;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end

            case (state)
                S_IDLE: begin
                    o_tx    <= 1'b1;
                    bit_cnt <= '0;
                    if (i_start) begin
                        o_tx  <= 1'b0;
                        state <= S_START;
                    end
                end

                S_START: begin
                    if (bit_end) begin
                        o_tx  <= shift_reg[0];
                        state <= S_DATA;
                    end
                end

                S_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BIT_LAST) begin
                            o_tx  <= 1'b1;
                            state <= S_STOP;
                        end else begin
                            // Next data bit, before the shift lands
                            o_tx    <= shift_reg[1];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                S_STOP: begin
                    if (bit_end) begin
                        o_done <= 1'b1;
                        state  <= S_IDLE;
                    end
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Byte captured at start, shifted out LSB first
    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && i_start) begin
            shift_reg <= i_data;
        end else if (state == S_DATA && bit_end) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

/* uart_word_tx_top.f */
common/uart_word_pkg.sv
hdl/word_fifo.sv
hdl/uart_buffer.sv
uart/uart_tx.sv
hdl/wb_tx_regs.sv
hdl/uart_word_tx_top.sv
tests/tb_uart_word_tx.sv
